//--- rob.f
source/rob_pkg.sv
source/rob_ifs.sv
source/dispatch_bridge.sv
source/rob.sv
source/arch_regfile.sv
source/rob_top.sv
verification/rob_assert.sv
verification/rob_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the rob testbench with verilator
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module rob_tb -Mdir "$BUILD_DIR" -f rob.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./"$BUILD_DIR"/Vrob_tb > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -qx "Simulation completed successfully" "$LOG"; then
    exit 0
fi
exit 1

//--- source/arch_regfile.sv
`timescale 1ns/1ps

module arch_regfile (
    input  logic           clk,
    input  logic           rst_n_i,
    rob_commit_if.sink     cmt,
    input  rob_pkg::areg_t raddr_i,
    output rob_pkg::xlen_t rdata_o
);
    import rob_pkg::*;

    // committed state
    xlen_t regs [NUM_AREG];

    ////////////////////
    // commit writes
    ////////////////////

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            regs <= '{default: '0};
        end else begin
            // lane 1 is younger, applied last so it wins a clash
            for (int l = 0; l < 2; l++) begin
                if (cmt.we[l] && (cmt.waddr[l] != '0)) begin
                    regs[cmt.waddr[l]] <= cmt.wdata[l];
                end
            end
        end
    end

    ////////////////////
    // read port
    ////////////////////

    // r0 hardwired to zero
    always_comb begin
        if (raddr_i == '0) begin
            rdata_o = '0;
        end else begin
            rdata_o = regs[raddr_i];
        end
    end

endmodule

//--- source/dispatch_bridge.sv
`timescale 1ns/1ps

module dispatch_bridge (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic                      req_i,
    output logic                      ack_o,
    input  logic [1:0]                lane_valid_i,
    input  rob_pkg::inst_type_t [1:0] type_i,
    input  rob_pkg::areg_t [1:0]      areg_i,
    input  rob_pkg::xlen_t [1:0]      pc_i,
    output rob_pkg::rob_idx_t         tag0_o,
    output rob_pkg::rob_idx_t         tag1_o,
    rob_dispatch_if.source            disp
);
    import rob_pkg::*;

    bridge_state_e state_q;
    bridge_state_e state_d;
    rob_cnt_t      lane_cnt;
    logic          room;
    logic          fire;
    rob_idx_t      tag0_q;
    rob_idx_t      tag1_q;

    ////////////////////
    // allocation decision
    ////////////////////

    // entries this request needs
    assign lane_cnt = rob_cnt_t'(lane_valid_i[0]) + rob_cnt_t'(lane_valid_i[1]);
    // wait until the rob can take all lanes at once
    assign room = (disp.free_cnt >= lane_cnt);
    // only one allocation per request, in idle
    assign fire = (state_q == IDLE) && req_i && room;

    // lane data is held stable by the source during req
    assign disp.alloc      = fire;
    assign disp.lane_valid = lane_valid_i;
    assign disp.inst_type  = type_i;
    assign disp.areg       = areg_i;
    assign disp.pc         = pc_i;

    ////////////////////
    // four-phase fsm
    ////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                // ack rises at the edge after allocation
                if (fire) begin
                    state_d = ACK;
                end
            end
            ACK: begin
                // source released req, drop ack
                if (!req_i) begin
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
            tag0_q  <= '0;
            tag1_q  <= '0;
        end else begin
            state_q <= state_d;
            // tags frozen for the whole ack phase
            if (fire) begin
                tag0_q <= disp.base_tag;
                tag1_q <= rob_idx_t'(disp.base_tag + 1'b1);
            end
        end
    end

    assign ack_o  = (state_q == ACK);
    assign tag0_o = tag0_q;
    assign tag1_o = tag1_q;

endmodule

//--- source/rob.sv
`timescale 1ns/1ps

module rob (
    input  logic           clk,
    input  logic           rst_n_i,
    rob_dispatch_if.sink   disp,
    rob_cdb_if.sink        cdb,
    rob_commit_if.source   cmt,
    output logic           exception_o,
    output rob_pkg::xlen_t exc_pc_o,
    output logic           empty_o
);
    import rob_pkg::*;

    // pointers and occupancy
    rob_idx_t head_q;
    rob_idx_t tail_q;
    rob_cnt_t count_q;

    // per-entry tables
    inst_type_t           ent_type [ROB_DEPTH];
    areg_t                ent_areg [ROB_DEPTH];
    xlen_t                ent_pc   [ROB_DEPTH];
    xlen_t                ent_data [ROB_DEPTH];
    logic                 ent_exc  [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] ent_done;

    rob_idx_t head1;
    logic     vld0;
    logic     vld1;
    logic     ret0;
    logic     ret1;
    logic     exc0_hit;
    logic     exc1_hit;
    logic     exc_hit;
    rob_cnt_t n_alloc;
    rob_cnt_t n_ret;
    logic     exc_q;
    xlen_t    exc_pc_q;

    ////////////////////
    // commit select
    ////////////////////

    assign head1 = rob_idx_t'(head_q + 1'b1);

    // oldest two entries, live and complete
    assign vld0 = (count_q >= rob_cnt_t'(1)) && ent_done[head_q];
    assign vld1 = (count_q >= rob_cnt_t'(2)) && ent_done[head1];

    // lane 1 strictly behind lane 0
    assign ret0 = vld0 && !ent_exc[head_q];
    assign ret1 = ret0 && vld1 && !ent_exc[head1];

    // excepting entry at the commit point does not retire
    assign exc0_hit = vld0 && ent_exc[head_q];
    assign exc1_hit = ret0 && vld1 && ent_exc[head1];
    assign exc_hit  = exc0_hit || exc1_hit;

    // only alu and load results reach the arf, r0 never written
    always_comb begin
        cmt.we[0]    = ret0 && (ent_type[head_q] inside {TYPE_ALU, TYPE_LOAD})
                       && (ent_areg[head_q] != '0);
        cmt.we[1]    = ret1 && (ent_type[head1] inside {TYPE_ALU, TYPE_LOAD})
                       && (ent_areg[head1] != '0);
        cmt.waddr[0] = ent_areg[head_q];
        cmt.waddr[1] = ent_areg[head1];
        cmt.wdata[0] = ent_data[head_q];
        cmt.wdata[1] = ent_data[head1];
    end

    ////////////////////
    // occupancy
    ////////////////////

    assign n_alloc = disp.alloc ? (rob_cnt_t'(disp.lane_valid[0])
                                   + rob_cnt_t'(disp.lane_valid[1])) : '0;
    assign n_ret   = rob_cnt_t'(ret0) + rob_cnt_t'(ret1);

    // no room while a flush is under way, new entries would be wiped
    assign disp.free_cnt = exc_hit ? '0 : rob_cnt_t'(ROB_DEPTH) - count_q;
    assign disp.base_tag = tail_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            head_q   <= '0;
            tail_q   <= '0;
            count_q  <= '0;
            ent_done <= '0;
            exc_q    <= 1'b0;
            exc_pc_q <= '0;
        end else begin
            exc_q <= exc_hit;
            if (exc_hit) begin
                // flush everything, report the faulting pc
                exc_pc_q <= exc0_hit ? ent_pc[head_q] : ent_pc[head1];
                head_q   <= '0;
                tail_q   <= '0;
                count_q  <= '0;
                ent_done <= '0;
            end else begin
                head_q  <= rob_idx_t'(head_q + n_ret);
                tail_q  <= rob_idx_t'(tail_q + n_alloc);
                // alloc and retire in one cycle net out
                count_q <= count_q + n_alloc - n_ret;
                if (cdb.valid) begin
                    ent_done[cdb.tag] <= 1'b1;
                end
                // fresh entries start incomplete
                for (int l = 0; l < 2; l++) begin
                    if (disp.alloc && disp.lane_valid[l]) begin
                        ent_done[rob_idx_t'(tail_q + l)] <= 1'b0;
                    end
                end
            end
        end
    end

    ////////////////////
    // payload tables
    ////////////////////

    always_ff @(posedge clk) begin
        for (int l = 0; l < 2; l++) begin
            if (disp.alloc && disp.lane_valid[l]) begin
                ent_type[rob_idx_t'(tail_q + l)] <= disp.inst_type[l];
                ent_areg[rob_idx_t'(tail_q + l)] <= disp.areg[l];
                ent_pc[rob_idx_t'(tail_q + l)]   <= disp.pc[l];
            end
        end
        // result and fault flag by tag
        if (cdb.valid) begin
            ent_data[cdb.tag] <= cdb.data;
            ent_exc[cdb.tag]  <= cdb.exc;
        end
    end

    assign exception_o = exc_q;
    assign exc_pc_o    = exc_pc_q;
    assign empty_o     = (count_q == '0);

endmodule

//--- source/rob_ifs.sv
`timescale 1ns/1ps

// dispatch bundle, bridge to rob
interface rob_dispatch_if;
    import rob_pkg::*;

    // one-cycle allocation strobe
    logic             alloc;
    // lane 1 only with lane 0
    logic [1:0]       lane_valid;
    inst_type_t [1:0] inst_type;
    areg_t [1:0]      areg;
    xlen_t [1:0]      pc;
    // back from rob
    rob_cnt_t         free_cnt;
    rob_idx_t         base_tag;

    modport source (output alloc, lane_valid, inst_type, areg, pc,
                    input free_cnt, base_tag);
    modport sink (input alloc, lane_valid, inst_type, areg, pc,
                  output free_cnt, base_tag);
endinterface

// common data bus, single result per cycle
interface rob_cdb_if;
    import rob_pkg::*;

    logic     valid;
    rob_idx_t tag;
    xlen_t    data;
    logic     exc;

    modport source (output valid, tag, data, exc);
    modport sink (input valid, tag, data, exc);
endinterface

// commit writes into the arf, lane 0 older
interface rob_commit_if;
    import rob_pkg::*;

    logic [1:0]  we;
    areg_t [1:0] waddr;
    xlen_t [1:0] wdata;

    modport source (output we, waddr, wdata);
    modport sink (input we, waddr, wdata);
endinterface

//--- source/rob_pkg.sv
package rob_pkg;

    ////////////////////
    // sizes
    ////////////////////

    // reorder buffer entries
    localparam int ROB_DEPTH = 64;
    // data and pc width
    localparam int XLEN      = 32;
    // architectural registers
    localparam int NUM_AREG  = 32;

    // derived index widths
    localparam int ROB_IDX_W = $clog2(ROB_DEPTH);
    localparam int AREG_W    = $clog2(NUM_AREG);

    ////////////////////
    // types
    ////////////////////

    // rob tag, also head and tail pointer
    typedef logic [ROB_IDX_W-1:0] rob_idx_t;
    // occupancy, needs one more bit to reach ROB_DEPTH
    typedef logic [ROB_IDX_W:0]   rob_cnt_t;
    // destination register number
    typedef logic [AREG_W-1:0]    areg_t;
    // result data and pc
    typedef logic [XLEN-1:0]      xlen_t;
    // instruction class
    typedef logic [1:0]           inst_type_t;

    // type codes
    localparam inst_type_t TYPE_ALU    = 2'd0;
    localparam inst_type_t TYPE_LOAD   = 2'd1;
    localparam inst_type_t TYPE_STORE  = 2'd2;
    localparam inst_type_t TYPE_BRANCH = 2'd3;

    // dispatch bridge fsm
    typedef enum logic {
        IDLE,
        ACK
    } bridge_state_e;

endpackage

//--- source/rob_top.sv
`timescale 1ns/1ps

module rob_top (
    input  logic                      clk,
    input  logic                      rst_n_i,
    // dispatch, four-phase req/ack
    input  logic                      dispatch_req_i,
    input  logic [1:0]                dispatch_lane_valid_i,
    input  rob_pkg::inst_type_t [1:0] dispatch_type_i,
    input  rob_pkg::areg_t [1:0]      dispatch_areg_i,
    input  rob_pkg::xlen_t [1:0]      dispatch_pc_i,
    output logic                      dispatch_ack_o,
    output rob_pkg::rob_idx_t         dispatch_tag0_o,
    output rob_pkg::rob_idx_t         dispatch_tag1_o,
    // write-back strobe
    input  logic                      cdb_valid_i,
    input  rob_pkg::rob_idx_t         cdb_tag_i,
    input  rob_pkg::xlen_t            cdb_data_i,
    input  logic                      cdb_exc_i,
    // exception report
    output logic                      exception_o,
    output rob_pkg::xlen_t            exc_pc_o,
    output logic                      rob_empty_o,
    // arf observation port
    input  rob_pkg::areg_t            arf_raddr_i,
    output rob_pkg::xlen_t            arf_rdata_o
);

    ////////////////////
    // internal bundles
    ////////////////////

    rob_dispatch_if disp_if ();
    rob_cdb_if      cdb_if ();
    rob_commit_if   cmt_if ();

    // cdb comes straight from the execution units
    assign cdb_if.valid = cdb_valid_i;
    assign cdb_if.tag   = cdb_tag_i;
    assign cdb_if.data  = cdb_data_i;
    assign cdb_if.exc   = cdb_exc_i;

    ////////////////////
    // blocks
    ////////////////////

    dispatch_bridge i_bridge (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .req_i        (dispatch_req_i),
        .ack_o        (dispatch_ack_o),
        .lane_valid_i (dispatch_lane_valid_i),
        .type_i       (dispatch_type_i),
        .areg_i       (dispatch_areg_i),
        .pc_i         (dispatch_pc_i),
        .tag0_o       (dispatch_tag0_o),
        .tag1_o       (dispatch_tag1_o),
        .disp         (disp_if.source)
    );

    rob i_rob (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .disp        (disp_if.sink),
        .cdb         (cdb_if.sink),
        .cmt         (cmt_if.source),
        .exception_o (exception_o),
        .exc_pc_o    (exc_pc_o),
        .empty_o     (rob_empty_o)
    );

    arch_regfile i_arf (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .cmt     (cmt_if.sink),
        .raddr_i (arf_raddr_i),
        .rdata_o (arf_rdata_o)
    );

endmodule

//--- verification/rob_assert.sv
`timescale 1ns/1ps

module rob_assert (
    input logic                   clk,
    input logic                   rst_n_i,
    input logic                   req_i,
    input logic                   ack_i,
    input logic [1:0]             lane_valid_i,
    input rob_pkg::bridge_state_e state_i,
    input logic                   alloc_i,
    input rob_pkg::rob_cnt_t      free_cnt_i
);
    import rob_pkg::*;

    // entries the current request asks for
    rob_cnt_t need;

    assign need = rob_cnt_t'(lane_valid_i[0]) + rob_cnt_t'(lane_valid_i[1]);

    ////////////////////
    // four-phase handshake
    ////////////////////

    // ack only drops once req has gone low
    a_ack_fall: assert property (@(posedge clk) disable iff (!rst_n_i)
        $fell(ack_i) |-> $past(!req_i))
        else $error("dispatch ack fell while req was still high");

    // a new request only after the previous ack is gone
    a_req_idle: assert property (@(posedge clk) disable iff (!rst_n_i)
        $rose(req_i) |-> (state_i == IDLE))
        else $error("dispatch req raised before the bridge returned to idle");

    ////////////////////
    // rob occupancy
    ////////////////////

    a_alloc_room: assert property (@(posedge clk) disable iff (!rst_n_i)
        alloc_i |-> (free_cnt_i >= need))
        else $error("allocation without enough free rob entries");

    // lanes fill from lane 0 up
    a_lane_order: assert property (@(posedge clk) disable iff (!rst_n_i)
        req_i |-> (lane_valid_i != 2'b10))
        else $error("lane 1 valid without lane 0");

endmodule

//--- verification/rob_tb.sv
`timescale 1ns/1ps

module rob_tb;
    import rob_pkg::*;

    // about 2000 cycles of stress plus well under 1000 for the rest
    localparam int TIMEOUT_CYCLES = 20000;
    localparam int STRESS_COUNT   = 200;

    logic             clk;
    logic             rst_n_i;
    logic             dispatch_req;
    logic [1:0]       dispatch_lane_valid;
    inst_type_t [1:0] dispatch_type;
    areg_t [1:0]      dispatch_areg;
    xlen_t [1:0]      dispatch_pc;
    logic             dispatch_ack;
    rob_idx_t         dispatch_tag0;
    rob_idx_t         dispatch_tag1;
    logic             cdb_valid;
    rob_idx_t         cdb_tag;
    xlen_t            cdb_data;
    logic             cdb_exc;
    logic             exception;
    xlen_t            exc_pc;
    logic             rob_empty;
    areg_t            arf_raddr;
    xlen_t            arf_rdata;

    // model queue with one element per live entry in program order
    rob_idx_t   q_tag  [$];
    inst_type_t q_type [$];
    areg_t      q_areg [$];
    xlen_t      q_pc   [$];
    xlen_t      q_data [$];
    logic       q_exc  [$];
    xlen_t      m_arf  [NUM_AREG];

    rob_idx_t    exp_tail;
    xlen_t       pc_next;
    logic [31:0] lcg_state;
    int          cycles;
    int          errors;
    int          exc_seen;
    xlen_t       exc_pc_seen;
    logic        exc_empty_seen;
    int          req_base;

    rob_top i_dut (
        .clk                   (clk),
        .rst_n_i               (rst_n_i),
        .dispatch_req_i        (dispatch_req),
        .dispatch_lane_valid_i (dispatch_lane_valid),
        .dispatch_type_i       (dispatch_type),
        .dispatch_areg_i       (dispatch_areg),
        .dispatch_pc_i         (dispatch_pc),
        .dispatch_ack_o        (dispatch_ack),
        .dispatch_tag0_o       (dispatch_tag0),
        .dispatch_tag1_o       (dispatch_tag1),
        .cdb_valid_i           (cdb_valid),
        .cdb_tag_i             (cdb_tag),
        .cdb_data_i            (cdb_data),
        .cdb_exc_i             (cdb_exc),
        .exception_o           (exception),
        .exc_pc_o              (exc_pc),
        .rob_empty_o           (rob_empty),
        .arf_raddr_i           (arf_raddr),
        .arf_rdata_o           (arf_rdata)
    );

    bind dispatch_bridge rob_assert i_rob_assert (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .req_i        (req_i),
        .ack_i        (ack_o),
        .lane_valid_i (lane_valid_i),
        .state_i      (state_q),
        .alloc_i      (disp.alloc),
        .free_cnt_i   (disp.free_cnt)
    );

    always #4 clk = ~clk;

    ////////////////////
    // run guards
    ////////////////////

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            halt_with_failure();
        end
    end

    // catch the one-cycle exception pulse
    always @(negedge clk) begin
        if (exception) begin
            exc_seen++;
            exc_pc_seen    = exc_pc;
            exc_empty_seen = rob_empty;
        end
    end

    task automatic halt_with_failure();
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_mismatch(string test, logic [31:0] exp, logic [31:0] act);
        errors++;
        $display("[FAIL] %s: expected %0h, actual %0h", test, exp, act);
        halt_with_failure();
    endtask

    task automatic check_value(string test, logic [31:0] exp, logic [31:0] act);
        assert (act === exp) else report_mismatch(test, exp, act);
    endtask

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    ////////////////////
    // bus helpers
    ////////////////////

    // raise req with the lanes and log them in the model
    task automatic drive_request(input logic [1:0] lanes, input inst_type_t [1:0] ty,
                                 input areg_t [1:0] ar, input xlen_t [1:0] dat);
        req_base = q_tag.size();
        @(posedge clk);
        dispatch_req        <= 1'b1;
        dispatch_lane_valid <= lanes;
        dispatch_type       <= ty;
        dispatch_areg       <= ar;
        for (int l = 0; l < 2; l++) begin
            dispatch_pc[l] <= pc_next;
            if (lanes[l]) begin
                q_tag.push_back(exp_tail);
                q_type.push_back(ty[l]);
                q_areg.push_back(ar[l]);
                q_pc.push_back(pc_next);
                q_data.push_back(dat[l]);
                q_exc.push_back(1'b0);
                exp_tail = exp_tail + rob_idx_t'(1);
                pc_next  = pc_next + 32'd4;
            end
        end
    endtask

    // ack may take any number of cycles under back-pressure
    task automatic finish_request(string test);
        rob_idx_t exp1;
        do begin
            @(negedge clk);
        end while (!dispatch_ack);
        exp1 = q_tag[req_base] + rob_idx_t'(1);
        check_value({test, " tag0"}, 32'(q_tag[req_base]), 32'(dispatch_tag0));
        check_value({test, " tag1"}, 32'(exp1), 32'(dispatch_tag1));
        @(posedge clk);
        dispatch_req <= 1'b0;
        do begin
            @(negedge clk);
        end while (dispatch_ack);
    endtask

    task automatic do_dispatch(string test, input logic [1:0] lanes, input inst_type_t [1:0] ty,
                               input areg_t [1:0] ar, input xlen_t [1:0] dat);
        drive_request(lanes, ty, ar, dat);
        finish_request(test);
    endtask

    task automatic do_writeback(rob_idx_t tag, xlen_t data, logic exc);
        @(posedge clk);
        cdb_valid <= 1'b1;
        cdb_tag   <= tag;
        cdb_data  <= data;
        cdb_exc   <= exc;
        @(posedge clk);
        cdb_valid <= 1'b0;
    endtask

    task automatic writeback_entry(int i);
        do_writeback(q_tag[i], q_data[i], q_exc[i]);
    endtask

    task automatic wait_empty();
        do begin
            @(negedge clk);
        end while (!rob_empty);
        // one more edge so the pulse monitor is up to date
        @(negedge clk);
    endtask

    // program order replay up to the first fault
    task automatic retire_model();
        for (int i = 0; i < q_tag.size(); i++) begin
            if (q_exc[i]) begin
                // flush restarts tags at zero
                exp_tail = '0;
                break;
            end
            if ((q_type[i] == TYPE_ALU || q_type[i] == TYPE_LOAD) && q_areg[i] != '0) begin
                m_arf[q_areg[i]] = q_data[i];
            end
        end
        q_tag.delete();
        q_type.delete();
        q_areg.delete();
        q_pc.delete();
        q_data.delete();
        q_exc.delete();
    endtask

    task automatic read_arf(string test);
        for (int r = 0; r < NUM_AREG; r++) begin
            @(posedge clk);
            arf_raddr <= areg_t'(r);
            @(negedge clk);
            check_value($sformatf("%s r%0d", test, r), m_arf[r], arf_rdata);
        end
    endtask

    ////////////////////
    // tests
    ////////////////////

    task automatic test_reset();
        @(negedge clk);
        check_value("reset ack", 32'(0), 32'(dispatch_ack));
        check_value("reset exception", 32'(0), 32'(exception));
        check_value("reset empty", 32'(1), 32'(rob_empty));
        read_arf("reset arf");
    endtask

    // entries 2 and 3 both hit r5 and retire in one cycle
    task automatic test_ooo_commit();
        do_dispatch("ooo", 2'b01, {TYPE_ALU, TYPE_ALU}, {5'd0, 5'd5}, {32'h0, 32'h1111_0000});
        do_dispatch("ooo", 2'b01, {TYPE_ALU, TYPE_LOAD}, {5'd0, 5'd6}, {32'h0, 32'h1111_0001});
        do_dispatch("ooo", 2'b11, {TYPE_LOAD, TYPE_ALU}, {5'd5, 5'd5},
                    {32'h1111_0003, 32'h1111_0002});
        do_dispatch("ooo", 2'b11, {TYPE_ALU, TYPE_LOAD}, {5'd7, 5'd6},
                    {32'h1111_0005, 32'h1111_0004});
        for (int i = q_tag.size() - 1; i >= 0; i--) begin
            writeback_entry(i);
        end
        wait_empty();
        retire_model();
        read_arf("ooo");
    endtask

    task automatic test_non_writing();
        do_dispatch("nowr", 2'b11, {TYPE_BRANCH, TYPE_STORE}, {5'd6, 5'd5},
                    {32'hdead_0002, 32'hdead_0001});
        do_dispatch("nowr", 2'b01, {TYPE_ALU, TYPE_ALU}, {5'd0, 5'd0}, {32'h0, 32'hdead_0003});
        for (int i = 0; i < q_tag.size(); i++) begin
            writeback_entry(i);
        end
        wait_empty();
        retire_model();
        read_arf("nowr");
    endtask

    task automatic test_exception();
        xlen_t fault_pc;
        do_dispatch("exc", 2'b11, {TYPE_ALU, TYPE_ALU}, {5'd9, 5'd8},
                    {32'he000_0001, 32'he000_0000});
        do_dispatch("exc", 2'b11, {TYPE_LOAD, TYPE_ALU}, {5'd11, 5'd10},
                    {32'he000_0003, 32'he000_0002});
        do_dispatch("exc", 2'b01, {TYPE_ALU, TYPE_ALU}, {5'd0, 5'd12}, {32'h0, 32'he000_0004});
        // third instruction faults
        q_exc[2] = 1'b1;
        fault_pc = q_pc[2];
        for (int i = q_tag.size() - 1; i >= 0; i--) begin
            writeback_entry(i);
        end
        wait_empty();
        check_value("exc pulse count", 32'(1), 32'(exc_seen));
        check_value("exc pc", fault_pc, exc_pc_seen);
        check_value("exc pulse width", 32'(0), 32'(exception));
        check_value("exc empty", 32'(1), 32'(exc_empty_seen));
        retire_model();
        read_arf("exc");
        do_dispatch("after exc", 2'b01, {TYPE_ALU, TYPE_ALU}, {5'd0, 5'd13},
                    {32'h0, 32'he000_0005});
        writeback_entry(0);
        wait_empty();
        retire_model();
        read_arf("after exc");
    endtask

    task automatic test_back_pressure();
        for (int i = 0; i < ROB_DEPTH / 2; i++) begin
            do_dispatch("bp fill", 2'b11, {TYPE_ALU, TYPE_LOAD},
                        {areg_t'(next_random()), areg_t'(next_random())},
                        {next_random(), next_random()});
        end
        drive_request(2'b01, {TYPE_ALU, TYPE_ALU}, {5'd0, 5'd3}, {32'h0, 32'hb0b0_0003});
        // rob full so the request must sit unacknowledged
        repeat (20) begin
            @(negedge clk);
            check_value("bp stall", 32'(0), 32'(dispatch_ack));
        end
        writeback_entry(0);
        finish_request("bp release");
        for (int i = 1; i < q_tag.size(); i++) begin
            writeback_entry(i);
        end
        wait_empty();
        retire_model();
        read_arf("bp");
    endtask

    task automatic test_random_stress();
        int               done_cnt;
        int               lanes;
        int               j;
        int               tmp;
        int               idx [$];
        inst_type_t [1:0] ty;
        areg_t [1:0]      ar;
        xlen_t [1:0]      dat;
        done_cnt = 0;
        while (done_cnt < STRESS_COUNT) begin
            // batches of about 40 stay clear of a full rob
            while (q_tag.size() < 40 && done_cnt < STRESS_COUNT) begin
                lanes = (next_random() % 32'd2 == 0 || done_cnt == STRESS_COUNT - 1) ? 1 : 2;
                for (int l = 0; l < 2; l++) begin
                    ty[l]  = inst_type_t'(next_random() % 32'd4);
                    ar[l]  = areg_t'(next_random() % 32'd32);
                    dat[l] = next_random();
                end
                do_dispatch("stress", (lanes == 2) ? 2'b11 : 2'b01, ty, ar, dat);
                done_cnt += lanes;
            end
            // fisher-yates over the batch
            idx.delete();
            for (int i = 0; i < q_tag.size(); i++) begin
                idx.push_back(i);
            end
            for (int i = idx.size() - 1; i > 0; i--) begin
                j = int'(next_random() % 32'(i + 1));
                tmp = idx[i];
                idx[i] = idx[j];
                idx[j] = tmp;
            end
            foreach (idx[k]) begin
                writeback_entry(idx[k]);
            end
            wait_empty();
            retire_model();
        end
        read_arf("stress");
    endtask

    initial begin
        clk                 = 1'b0;
        rst_n_i             = 1'b0;
        dispatch_req        = 1'b0;
        dispatch_lane_valid = '0;
        dispatch_type       = '0;
        dispatch_areg       = '0;
        dispatch_pc         = '0;
        cdb_valid           = 1'b0;
        cdb_tag             = '0;
        cdb_data            = '0;
        cdb_exc             = 1'b0;
        arf_raddr           = '0;
        lcg_state           = 32'h632d7bfe;
        cycles              = 0;
        errors              = 0;
        exc_seen            = 0;
        exc_pc_seen         = '0;
        exc_empty_seen      = 1'b0;
        exp_tail            = '0;
        pc_next             = 32'h0000_1000;
        req_base            = 0;
        m_arf               = '{default: '0};
        repeat (5) @(posedge clk);
        rst_n_i <= 1'b1;
        test_reset();
        test_ooo_commit();
        test_non_writing();
        test_exception();
        test_back_pressure();
        test_random_stress();
        // only the exception test may fault
        check_value("final pulse count", 32'(1), 32'(exc_seen));
        if (errors == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            halt_with_failure();
        end
    end

endmodule
